//--- Makefile
# Verilator flow for the wormhole receive path

VERILATOR  ?= verilator
TB_TOP     ?= tb_wormhole_stream_rx
RTL_TOP    ?= wormhole_stream_rx
FILELIST   ?= wormhole_stream_rx.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Simulation completed successfully
LINT_FLAGS ?= -Wall -Wno-fatal
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "sim: pass"; \
	else \
	  echo "sim: fail, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_wormhole_stream_rx.sv
module tb_wormhole_stream_rx;

  // one table row describes a whole packet and data byte k is base plus k
  typedef struct packed
  {
    logic [7:0]  opcode;
    logic [31:0] addr;
    logic [7:0]  cord;
    logic [7:0]  beats;
    logic [7:0]  base;
  } pkt_row_s;

  localparam int num_pkts_lp = 10;
  // unused byte lanes of a partial flit carry this value and no table byte equals it
  localparam logic [7:0] poison_lp = 8'hff;
  localparam int flit_timeout_lp = 500;
  localparam int drain_timeout_lp = 5000;

  logic clk_i;
  logic rst_n_i;
  logic [wh_stream_pkg::flit_width_lp-1:0] link_data_i;
  logic link_v_i;
  logic link_ready_o;
  wh_stream_pkg::dma_hdr_s dma_hdr_o;
  logic dma_hdr_v_o;
  logic dma_hdr_ready_i;
  logic [wh_stream_pkg::pr_data_width_lp-1:0] data_o;
  logic data_v_o;
  logic data_ready_i;

  pkt_row_s pkt_table [num_pkts_lp];
  wh_stream_pkg::dma_hdr_s exp_hdr_q [$];
  logic [7:0] exp_data_q [$];
  int pkt_err [num_pkts_lp];
  int errors;
  int checks;
  int hdr_done_cnt;
  int data_done_cnt;
  int beat_cnt;
  int report_idx;
  logic ready_en;
  logic sent_ok;
  wh_stream_pkg::dma_hdr_s exp_hdr;
  logic [7:0] exp_byte;

  always #5 clk_i = ~clk_i;

  wormhole_stream_rx dut
  (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .link_data_i     (link_data_i),
    .link_v_i        (link_v_i),
    .link_ready_o    (link_ready_o),
    .dma_hdr_o       (dma_hdr_o),
    .dma_hdr_v_o     (dma_hdr_v_o),
    .dma_hdr_ready_i (dma_hdr_ready_i),
    .data_o          (data_o),
    .data_v_o        (data_v_o),
    .data_ready_i    (data_ready_i)
  );

  // rows 4 and 5 put a one beat packet right before a thirteen beat packet
  task automatic load_table();
    pkt_table[0] = '{8'h01, 32'h1000_0000, 8'h11, 8'd4, 8'h10};
    pkt_table[1] = '{8'h02, 32'h2000_0040, 8'h22, 8'd1, 8'h20};
    pkt_table[2] = '{8'h03, 32'h3000_0080, 8'h33, 8'd5, 8'h30};
    pkt_table[3] = '{8'h04, 32'hdead_beec, 8'h44, 8'd6, 8'h40};
    pkt_table[4] = '{8'h05, 32'h0000_0100, 8'h55, 8'd1, 8'h50};
    pkt_table[5] = '{8'h06, 32'h1234_5678, 8'h66, 8'd13, 8'h60};
    pkt_table[6] = '{8'h07, 32'h8765_4320, 8'h77, 8'd8, 8'h80};
    pkt_table[7] = '{8'h08, 32'hcafe_0000, 8'h88, 8'd2, 8'h90};
    pkt_table[8] = '{8'h09, 32'h0bad_f00c, 8'h99, 8'd3, 8'ha0};
    pkt_table[9] = '{8'h0a, 32'h5555_aaa0, 8'haa, 8'd16, 8'hc0};
  endtask

  // the client header echoes the cord as source and carries beats minus one
  task automatic build_expected();
    wh_stream_pkg::dma_hdr_s h;
    for (int p = 0; p < num_pkts_lp; p++)
    begin
      h.opcode = pkt_table[p].opcode;
      h.addr = pkt_table[p].addr;
      h.pr_len = pkt_table[p].beats - 8'd1;
      h.src_cord = pkt_table[p].cord;
      exp_hdr_q.push_back(h);
      for (int k = 0; k < pkt_table[p].beats; k++)
      begin
        exp_data_q.push_back(pkt_table[p].base + k[7:0]);
      end
      pkt_err[p] = 0;
    end
  endtask

  task automatic check_idle(input string phase);
    assert (!link_ready_o && !dma_hdr_v_o && !data_v_o)
    else
    begin
      $display("FAILED at %0t: outputs active %s", $time, phase);
      errors++;
    end
  endtask

  // holds one flit on the link until the DUT takes it
  task automatic drive_flit(input logic [wh_stream_pkg::flit_width_lp-1:0] flit,
                            output logic ok);
    int waited;
    link_v_i <= 1'b1;
    link_data_i <= flit;
    @(posedge clk_i);
    waited = 1;
    while (!link_ready_o && waited < flit_timeout_lp)
    begin
      @(posedge clk_i);
      waited++;
    end
    ok = link_ready_o;
    if (!ok)
    begin
      $display("timeout: link flit %h was not taken within %0d cycles", flit, flit_timeout_lp);
      errors++;
    end
  endtask

  // two header flits with cord in the low bits, then data flits with beat 0 in the low byte
  task automatic send_packet(input pkt_row_s row, output logic ok);
    wh_stream_pkg::wh_hdr_u hw;
    logic [wh_stream_pkg::flit_width_lp-1:0] flits [$];
    logic [wh_stream_pkg::flit_width_lp-1:0] word;
    int data_flits;
    int k;
    data_flits = (row.beats + 3) / 4;
    hw.hdr.cord = row.cord;
    hw.hdr.len = 8'(1 + data_flits);
    hw.hdr.opcode = row.opcode;
    hw.hdr.addr = row.addr;
    hw.hdr.pr_len = row.beats - 8'd1;
    flits.push_back(hw.flits[0]);
    flits.push_back(hw.flits[1]);
    for (int f = 0; f < data_flits; f++)
    begin
      for (int lane = 0; lane < wh_stream_pkg::beats_per_flit_lp; lane++)
      begin
        k = f * wh_stream_pkg::beats_per_flit_lp + lane;
        word[lane*8 +: 8] = (k < row.beats) ? row.base + k[7:0] : poison_lp;
      end
      flits.push_back(word);
    end
    ok = 1'b1;
    for (int i = 0; i < flits.size() && ok; i++)
    begin
      // now and then the link goes idle for a few cycles
      if ($urandom % 4 == 0)
      begin
        link_v_i <= 1'b0;
        repeat (1 + $urandom % 3) @(posedge clk_i);
      end
      drive_flit(flits[i], ok);
    end
  endtask

  task automatic wait_reports();
    int waited;
    waited = 0;
    while (report_idx < num_pkts_lp && waited < drain_timeout_lp)
    begin
      @(posedge clk_i);
      waited++;
    end
    if (report_idx < num_pkts_lp)
    begin
      $display("timeout: only %0d of %0d packets came out within %0d cycles",
               report_idx, num_pkts_lp, drain_timeout_lp);
      errors++;
    end
  endtask

  // both client ready inputs toggle at random once reset is over
  always @(posedge clk_i)
  begin
    if (ready_en)
    begin
      dma_hdr_ready_i <= ($urandom % 4) != 0;
      data_ready_i <= ($urandom % 3) != 0;
    end
  end

  // the header monitor expects headers in table order
  always @(posedge clk_i)
  begin
    if (rst_n_i && dma_hdr_v_o && dma_hdr_ready_i)
    begin
      assert (exp_hdr_q.size() != 0)
      else
      begin
        $display("a header came out at %0t with no packet left to send one", $time);
        errors++;
      end
      if (exp_hdr_q.size() != 0)
      begin
        exp_hdr = exp_hdr_q.pop_front();
        checks++;
        assert (dma_hdr_o == exp_hdr)
        else
        begin
          $display("FAILED at %0t: packet %0d header %h, expected %h",
                   $time, hdr_done_cnt, dma_hdr_o, exp_hdr);
          errors++;
          pkt_err[hdr_done_cnt]++;
        end
        hdr_done_cnt++;
      end
    end
  end

  // the data monitor closes a packet once its beat count has been taken
  always @(posedge clk_i)
  begin
    if (rst_n_i && data_v_o && data_ready_i)
    begin
      assert (data_o != poison_lp)
      else
      begin
        $display("FAILED at %0t: poison byte from an unused lane on the data output", $time);
        errors++;
      end
      assert (exp_data_q.size() != 0)
      else
      begin
        $display("a data beat came out at %0t after all packets were complete", $time);
        errors++;
      end
      if (exp_data_q.size() != 0)
      begin
        exp_byte = exp_data_q.pop_front();
        checks++;
        assert (data_o == exp_byte)
        else
        begin
          $display("FAILED at %0t: packet %0d beat %0d is %h, expected %h",
                   $time, data_done_cnt, beat_cnt, data_o, exp_byte);
          errors++;
          pkt_err[data_done_cnt]++;
        end
        beat_cnt++;
        if (beat_cnt == int'(pkt_table[data_done_cnt].beats))
        begin
          beat_cnt = 0;
          data_done_cnt++;
        end
      end
    end
  end

  // a packet is reported once both its header and its last beat are out
  always @(posedge clk_i)
  begin
    if (report_idx < num_pkts_lp && hdr_done_cnt > report_idx && data_done_cnt > report_idx)
    begin
      if (pkt_err[report_idx] == 0)
      begin
        $display("packet %0d: %0d beats ok", report_idx, pkt_table[report_idx].beats);
      end
      else
      begin
        $display("packet %0d: %0d beats, %0d errors",
                 report_idx, pkt_table[report_idx].beats, pkt_err[report_idx]);
      end
      report_idx++;
    end
  end

  initial
  begin
    void'($urandom(52));
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    link_data_i = '0;
    link_v_i = 1'b0;
    dma_hdr_ready_i = 1'b0;
    data_ready_i = 1'b0;
    ready_en = 1'b0;
    errors = 0;
    checks = 0;
    hdr_done_cnt = 0;
    data_done_cnt = 0;
    beat_cnt = 0;
    report_idx = 0;
    load_table();
    build_expected();
    for (int c = 0; c < 3; c++)
    begin
      @(posedge clk_i);
      check_idle("during reset");
    end
    rst_n_i <= 1'b1;
    // nothing may move after reset until the link presents a flit
    for (int c = 0; c < 2; c++)
    begin
      @(posedge clk_i);
      check_idle("after reset with no stimulus");
    end
    ready_en <= 1'b1;
    sent_ok = 1'b1;
    for (int p = 0; p < num_pkts_lp && sent_ok; p++)
    begin
      send_packet(pkt_table[p], sent_ok);
    end
    link_v_i <= 1'b0;
    wait_reports();
    // a quiet stretch catches any repeated beat or header
    repeat (20) @(posedge clk_i);
    assert (exp_hdr_q.size() == 0 && exp_data_q.size() == 0)
    else
    begin
      $display("%0d headers and %0d beats never came out", exp_hdr_q.size(), exp_data_q.size());
      errors++;
    end
    $display("%0d of %0d packets, %0d checks, %0d errors",
             report_idx, num_pkts_lp, checks, errors);
    if (errors == 0)
    begin
      $display("Simulation completed successfully");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- common/wh_stream_pkg.sv
package wh_stream_pkg;

  // link side widths, one flit is the unit moved per link handshake
  localparam int flit_width_lp = 32;
  localparam int cord_width_lp = 8;
  // link length counts the flits that follow the first flit
  localparam int len_width_lp  = 8;

  // protocol side widths, pr_len holds the beat count minus one
  localparam int pr_data_width_lp = 8;
  localparam int pr_len_width_lp  = 8;
  localparam int opcode_width_lp  = 8;
  localparam int addr_width_lp    = 32;

  // wormhole header plus protocol header fill exactly two flits
  localparam int hdr_width_lp = 64;
  localparam int hdr_flits_lp = hdr_width_lp / flit_width_lp;

  // slot index inside the gatherer and a header flit counter that can reach hdr_flits_lp
  localparam int hdr_idx_width_lp = $clog2(hdr_flits_lp);
  localparam int hdr_cnt_width_lp = $clog2(hdr_flits_lp + 1);
  localparam logic [hdr_idx_width_lp-1:0] hdr_last_idx_lp = hdr_idx_width_lp'(hdr_flits_lp - 1);
  localparam logic [hdr_cnt_width_lp-1:0] hdr_cnt_full_lp = hdr_cnt_width_lp'(hdr_flits_lp);

  // each data flit carries four protocol beats, beat 0 in the low byte
  localparam int beats_per_flit_lp = flit_width_lp / pr_data_width_lp;
  localparam int lg_beats_lp       = $clog2(beats_per_flit_lp);
  localparam logic [lg_beats_lp-1:0] beat_last_lp = lg_beats_lp'(beats_per_flit_lp - 1);

  // header fields with cord in the lowest bits, so the struct lists them msb first
  typedef struct packed
  {
    logic [pr_len_width_lp-1:0] pr_len;
    logic [addr_width_lp-1:0]   addr;
    logic [opcode_width_lp-1:0] opcode;
    logic [len_width_lp-1:0]    len;
    logic [cord_width_lp-1:0]   cord;
  } wh_hdr_s;

  // the gatherer fills the word flit by flit, the decoder reads it as fields
  typedef union packed
  {
    logic [hdr_flits_lp-1:0][flit_width_lp-1:0] flits;
    wh_hdr_s                                    hdr;
  } wh_hdr_u;

  // client view of a header, the destination cord comes back as the source
  typedef struct packed
  {
    logic [opcode_width_lp-1:0] opcode;
    logic [addr_width_lp-1:0]   addr;
    logic [pr_len_width_lp-1:0] pr_len;
    logic [cord_width_lp-1:0]   src_cord;
  } dma_hdr_s;

endpackage

//--- logic/dma_hdr_capture.sv
module dma_hdr_capture
  (
    input  logic                                      clk_i,
    input  logic                                      rst_n_i,

    // header word from the converter
    input  wh_stream_pkg::wh_hdr_u                    hdr_i,
    input  logic                                      hdr_v_i,
    output logic                                      hdr_ready_o,
    // beat count minus one, valid in the accept cycle
    output logic [wh_stream_pkg::pr_len_width_lp-1:0] pr_data_flits_o,

    // decoded header for the client
    output wh_stream_pkg::dma_hdr_s                   dma_hdr_o,
    output logic                                      dma_hdr_v_o,
    input  logic                                      dma_hdr_ready_i
  );

  logic full_r;
  wh_stream_pkg::dma_hdr_s dma_hdr_r;
  wh_stream_pkg::dma_hdr_s dma_hdr_n;
  logic hdr_accept;

  // the slot takes a new header when empty or when the client drains it this cycle
  assign hdr_ready_o = ~full_r | dma_hdr_ready_i;
  assign hdr_accept  = hdr_v_i & hdr_ready_o;

  // the converter loads its beat counter straight from the incoming field
  assign pr_data_flits_o = hdr_i.hdr.pr_len;

  // only the fields the client needs are kept, the link length is dropped here
  always_comb
  begin
    dma_hdr_n.opcode   = hdr_i.hdr.opcode;
    dma_hdr_n.addr     = hdr_i.hdr.addr;
    dma_hdr_n.pr_len   = hdr_i.hdr.pr_len;
    dma_hdr_n.src_cord = hdr_i.hdr.cord;
  end

  assign dma_hdr_o   = dma_hdr_r;
  assign dma_hdr_v_o = full_r;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      full_r <= 1'b0;
    end
    else if (hdr_accept)
    begin
      full_r <= 1'b1;
    end
    else if (dma_hdr_ready_i)
    begin
      full_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (hdr_accept)
    begin
      dma_hdr_r <= dma_hdr_n;
    end
  end

endmodule

//--- logic/parallel_in_serial_out_dynamic.sv
module parallel_in_serial_out_dynamic
  (
    input  logic                                      clk_i,
    input  logic                                      rst_n_i,

    // one data flit from the link is held until ready_o
    input  logic [wh_stream_pkg::flit_width_lp-1:0]   data_i,
    input  logic                                      v_i,
    output logic                                      ready_o,

    // protocol beats of one byte each
    output logic [wh_stream_pkg::pr_data_width_lp-1:0] data_o,
    output logic                                      v_o,
    input  logic                                      ready_i,

    // first_o marks beat 0 of a flit when len_i must be presented
    output logic                                      first_o,
    // zero based index of the last beat in this flit
    input  logic [wh_stream_pkg::lg_beats_lp-1:0]     len_i
  );

  // index of the beat on the output
  logic [wh_stream_pkg::lg_beats_lp-1:0] idx_r;
  // last beat index captured at beat 0
  logic [wh_stream_pkg::lg_beats_lp-1:0] len_r;
  // later beats are read from this copy of the flit
  logic [wh_stream_pkg::beats_per_flit_lp-1:0][wh_stream_pkg::pr_data_width_lp-1:0] flit_r;
  logic [wh_stream_pkg::lg_beats_lp-1:0] cur_len;
  logic last_beat;
  logic beat_accept;

  assign first_o = (idx_r == '0);

  // on beat 0 the length is still on the input and has not been captured yet
  assign cur_len = first_o ? len_i : len_r;
  assign last_beat = (idx_r == cur_len);

  // beat 0 goes straight from the link so there is no added latency
  assign data_o = first_o ? data_i[wh_stream_pkg::pr_data_width_lp-1:0] : flit_r[idx_r];
  assign v_o = v_i;

  assign beat_accept = v_o & ready_i;

  // the link flit is released together with the beat that ends it
  assign ready_o = beat_accept & last_beat;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      idx_r <= '0;
      len_r <= '0;
    end
    else if (beat_accept)
    begin
      if (last_beat)
      begin
        idx_r <= '0;
      end
      else
      begin
        idx_r <= idx_r + 1'b1;
      end

      if (first_o)
      begin
        len_r <= len_i;
      end
    end
  end

  // the whole flit is copied on beat 0 for the beats that follow
  always_ff @(posedge clk_i)
  begin
    if (beat_accept & first_o)
    begin
      flit_r <= data_i;
    end
  end

endmodule

//--- logic/serial_in_parallel_out.sv
module serial_in_parallel_out
  (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,

    // incoming header flits from the link
    input  logic [wh_stream_pkg::flit_width_lp-1:0] data_i,
    input  logic                                   v_i,
    output logic                                   ready_o,

    // the whole header word
    output wh_stream_pkg::wh_hdr_u                 data_o,
    output logic                                   v_o,
    input  logic                                   ready_i
  );

  // slot the next flit goes into
  logic [wh_stream_pkg::hdr_idx_width_lp-1:0] idx_r;
  // earlier flits of the header, the last one never gets stored
  logic [wh_stream_pkg::hdr_flits_lp-2:0][wh_stream_pkg::flit_width_lp-1:0] flit_r;
  logic last_slot;
  logic store;

  assign last_slot = (idx_r == wh_stream_pkg::hdr_last_idx_lp);

  // the word is complete only while the last flit sits on the input
  assign v_o = v_i & last_slot;

  // earlier slots always have room, the last one waits on the consumer
  assign ready_o = v_i & (last_slot ? ready_i : 1'b1);

  assign store = v_i & ~last_slot;

  // stored flits come first in the word, the last flit passes straight through
  always_comb
  begin
    for (int i = 0; i < wh_stream_pkg::hdr_flits_lp - 1; i++)
    begin
      data_o.flits[i] = flit_r[i];
    end
    data_o.flits[wh_stream_pkg::hdr_flits_lp-1] = data_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      idx_r <= '0;
    end
    else if (v_o & ready_i)
    begin
      // header handed over, start again at slot 0 for the next packet
      idx_r <= '0;
    end
    else if (store)
    begin
      idx_r <= idx_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (store)
    begin
      flit_r[idx_r] <= data_i;
    end
  end

endmodule

//--- logic/wormhole_stream_control.sv
module wormhole_stream_control
  (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,

    // the length field is only meaningful on the first flit of a packet
    input  logic [wh_stream_pkg::len_width_lp-1:0] len_i,
    // a flit moves across the link this cycle
    input  logic                                  link_accept_i,

    output logic                                  is_hdr_o,
    output logic                                  is_data_o
  );

  // a packet is in flight after its first flit
  logic active_r;
  // flits still to come after the current one
  logic [wh_stream_pkg::len_width_lp-1:0] cnt_r;
  // header flits seen so far in this packet
  logic [wh_stream_pkg::hdr_cnt_width_lp-1:0] hdr_seen_r;
  logic hdr_done;

  assign hdr_done = (hdr_seen_r == wh_stream_pkg::hdr_cnt_full_lp);

  // when idle the next flit opens a packet and is always a header flit
  assign is_hdr_o  = ~active_r | ~hdr_done;
  assign is_data_o = active_r & hdr_done;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      active_r   <= 1'b0;
      cnt_r      <= '0;
      hdr_seen_r <= '0;
    end
    else if (link_accept_i)
    begin
      if (!active_r)
      begin
        // the first flit loads the count of flits that follow it
        active_r   <= (len_i != '0);
        cnt_r      <= len_i;
        hdr_seen_r <= 'd1;
      end
      else
      begin
        cnt_r <= cnt_r - 1'b1;
        if (!hdr_done)
        begin
          hdr_seen_r <= hdr_seen_r + 1'b1;
        end
        // the final flit of the packet returns us to idle
        if (cnt_r == 'd1)
        begin
          active_r <= 1'b0;
        end
      end
    end
  end

endmodule

//--- logic/wormhole_stream_rx.sv
module wormhole_stream_rx
  (
    input  logic                                       clk_i,
    input  logic                                       rst_n_i,

    // wormhole link input
    input  logic [wh_stream_pkg::flit_width_lp-1:0]    link_data_i,
    input  logic                                       link_v_i,
    output logic                                       link_ready_o,

    // decoded header stream
    output wh_stream_pkg::dma_hdr_s                    dma_hdr_o,
    output logic                                       dma_hdr_v_o,
    input  logic                                       dma_hdr_ready_i,

    // protocol data stream
    output logic [wh_stream_pkg::pr_data_width_lp-1:0] data_o,
    output logic                                       data_v_o,
    input  logic                                       data_ready_i
  );

  wh_stream_pkg::wh_hdr_u hdr;
  logic hdr_v;
  logic hdr_ready;
  logic [wh_stream_pkg::pr_len_width_lp-1:0] pr_data_flits;

  wormhole_stream_out stream_out
  (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .link_data_i     (link_data_i),
    .link_v_i        (link_v_i),
    .link_ready_o    (link_ready_o),
    .hdr_o           (hdr),
    .hdr_v_o         (hdr_v),
    .hdr_ready_i     (hdr_ready),
    .pr_data_flits_i (pr_data_flits),
    .data_o          (data_o),
    .data_v_o        (data_v_o),
    .data_ready_i    (data_ready_i)
  );

  // decodes the header and tells the converter how many beats follow
  dma_hdr_capture hdr_capture
  (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .hdr_i           (hdr),
    .hdr_v_i         (hdr_v),
    .hdr_ready_o     (hdr_ready),
    .pr_data_flits_o (pr_data_flits),
    .dma_hdr_o       (dma_hdr_o),
    .dma_hdr_v_o     (dma_hdr_v_o),
    .dma_hdr_ready_i (dma_hdr_ready_i)
  );

endmodule

//--- wormhole_stream_out/wormhole_stream_out.sv
module wormhole_stream_out
  (
    input  logic                                      clk_i,
    input  logic                                      rst_n_i,

    // flits from the wormhole link
    input  logic [wh_stream_pkg::flit_width_lp-1:0]   link_data_i,
    input  logic                                      link_v_i,
    output logic                                      link_ready_o,

    // assembled header word
    output wh_stream_pkg::wh_hdr_u                    hdr_o,
    output logic                                      hdr_v_o,
    input  logic                                      hdr_ready_i,
    // beat count minus one, returned during the header handshake
    input  logic [wh_stream_pkg::pr_len_width_lp-1:0] pr_data_flits_i,

    // protocol data beats
    output logic [wh_stream_pkg::pr_data_width_lp-1:0] data_o,
    output logic                                      data_v_o,
    input  logic                                      data_ready_i
  );

  logic is_hdr;
  logic is_data;
  logic hdr_v_li;
  logic hdr_ready_lo;
  logic data_v_li;
  logic data_ready_lo;
  logic piso_first_lo;
  logic [wh_stream_pkg::lg_beats_lp-1:0] piso_len_li;
  // beats left in the packet minus one, including the beat on the output
  logic [wh_stream_pkg::pr_len_width_lp-1:0] pr_data_cnt_r;
  logic pr_data_consumed;
  logic hdr_accept;
  logic beat_accept;

  // the link valid only reaches the side the current flit belongs to
  assign hdr_v_li  = is_hdr & link_v_i;
  assign data_v_li = is_data & link_v_i;

  assign link_ready_o = is_hdr ? hdr_ready_lo : data_ready_lo;

  // header flits are gathered into one word for the capture stage
  serial_in_parallel_out hdr_sipo
  (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (link_data_i),
    .v_i     (hdr_v_li),
    .ready_o (hdr_ready_lo),
    .data_o  (hdr_o),
    .v_o     (hdr_v_o),
    .ready_i (hdr_ready_i)
  );

  assign hdr_accept  = hdr_v_o & hdr_ready_i;
  assign beat_accept = data_v_o & data_ready_i;
  assign pr_data_consumed = (pr_data_cnt_r == '0);

  // the count is loaded from the decoded header and stops at zero on the final beat
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      pr_data_cnt_r <= '0;
    end
    else if (hdr_accept)
    begin
      pr_data_cnt_r <= pr_data_flits_i;
    end
    else if (beat_accept & ~pr_data_consumed)
    begin
      pr_data_cnt_r <= pr_data_cnt_r - 1'b1;
    end
  end

  // a full flit ends at beat 3, the last flit of a packet may end earlier
  always_comb
  begin
    piso_len_li = '0;
    if (piso_first_lo)
    begin
      if (pr_data_cnt_r >= wh_stream_pkg::pr_len_width_lp'(wh_stream_pkg::beat_last_lp))
      begin
        piso_len_li = wh_stream_pkg::beat_last_lp;
      end
      else
      begin
        piso_len_li = pr_data_cnt_r[wh_stream_pkg::lg_beats_lp-1:0];
      end
    end
  end

  // each data flit is split into bytes without waiting for the rest of the packet
  parallel_in_serial_out_dynamic data_piso
  (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (link_data_i),
    .v_i     (data_v_li),
    .ready_o (data_ready_lo),
    .data_o  (data_o),
    .v_o     (data_v_o),
    .ready_i (data_ready_i),
    .first_o (piso_first_lo),
    .len_i   (piso_len_li)
  );

  // labels each link flit as header or data from the link length field
  wormhole_stream_control stream_control
  (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .len_i         (link_data_i[wh_stream_pkg::cord_width_lp +: wh_stream_pkg::len_width_lp]),
    .link_accept_i (link_ready_o & link_v_i),
    .is_hdr_o      (is_hdr),
    .is_data_o     (is_data)
  );

endmodule

//--- wormhole_stream_rx.f
common/wh_stream_pkg.sv
logic/serial_in_parallel_out.sv
logic/parallel_in_serial_out_dynamic.sv
logic/wormhole_stream_control.sv
wormhole_stream_out/wormhole_stream_out.sv
logic/dma_hdr_capture.sv
logic/wormhole_stream_rx.sv
bench/tb_wormhole_stream_rx.sv
